// ==== common/ctrl_pkg.sv ====
////////////////////////////////////////
// controller state and pc types
////////////////////////////////////////

`default_nettype none

package ctrl_pkg;

  // main controller FSM states
  typedef enum logic [2:0] {
    RESET,
    BOOT_SET,
    SLEEP,
    FIRST_FETCH,
    DECODE,
    FLUSH_EX,
    FLUSH_WB
  } ctrl_state_t;

  // pc source select for the fetch stage
  typedef enum logic [2:0] {
    PC_BOOT,
    PC_JUMP,
    PC_BRANCH,
    PC_EXCEPTION,
    PC_ERET
  } pc_sel_t;

  // kind of control transfer seen by the decoder
  typedef enum logic [1:0] {
    BRANCH_NONE,
    BRANCH_JAL,
    BRANCH_JALR,
    BRANCH_COND
  } jump_kind_t;

endpackage

`default_nettype wire

// ==== common/fwd_pkg.sv ====
////////////////////////////////////////
// forwarding definitions
////////////////////////////////////////

`default_nettype none

package fwd_pkg;

  // register file address width
  localparam int REG_ADDR_W = 5;
  // source operands a, b and c
  localparam int NUM_OPS = 3;

  typedef logic [REG_ADDR_W-1:0] reg_addr_t;

  // operand mux select, code 2'b11 is unused
  typedef enum logic [1:0] {
    SEL_REGFILE,
    SEL_FW_EX,
    SEL_FW_WB
  } fwd_sel_t;

endpackage

`default_nettype wire

// ==== controller/ctrl_fsm.sv ====
////////////////////////////////////////
// main control FSM
////////////////////////////////////////

`timescale 1ns/1ps
`default_nettype none

module ctrl_fsm
(
  input  wire logic                 clk,
  input  wire logic                 rst_n,

  input  wire logic                 fetch_enable_i,
  input  wire logic                 instr_valid_i,
  input  wire logic                 eret_insn_i,
  input  wire logic                 pipe_flush_i,
  input  wire ctrl_pkg::jump_kind_t jump_in_dec_i,
  input  wire logic                 branch_taken_ex_i,
  input  wire logic                 exc_req_i,
  input  wire logic                 jr_stall_i,
  input  wire logic                 id_valid_i,
  input  wire logic                 ex_valid_i,
  input  wire logic                 wb_valid_i,

  output logic                      core_busy_o,
  output logic                      is_decoding_o,
  output logic                      instr_req_o,
  output logic                      pc_set_o,
  output ctrl_pkg::pc_sel_t         pc_mux_o,
  output logic                      exc_ack_o,
  output logic                      exc_save_id_o,
  output logic                      exc_restore_id_o,
  output logic                      halt_if_o,
  output logic                      halt_id_o
);

  ctrl_pkg::ctrl_state_t state_q;
  ctrl_pkg::ctrl_state_t state_ns;

  // set once a jump or eret redirect went out for the instruction in ID
  logic jump_done;
  logic jump_done_q;

  ////////////////////////////////////////
  // next state and outputs
  ////////////////////////////////////////
  always_comb
  begin
    // defaults, core running and fetching
    instr_req_o      = 1'b1;
    core_busy_o      = 1'b1;
    is_decoding_o    = 1'b0;
    exc_ack_o        = 1'b0;
    exc_save_id_o    = 1'b0;
    exc_restore_id_o = 1'b0;
    pc_mux_o         = ctrl_pkg::PC_BOOT;
    pc_set_o         = 1'b0;
    halt_if_o        = 1'b0;
    halt_id_o        = 1'b0;
    jump_done        = jump_done_q;
    state_ns         = state_q;

    unique case (state_q)
      // idle after reset until fetching is enabled
      ctrl_pkg::RESET:
      begin
        core_busy_o = 1'b0;
        instr_req_o = 1'b0;
        if (fetch_enable_i)
          state_ns = ctrl_pkg::BOOT_SET;
      end

      // load boot address into the fetch pc, single cycle
      ctrl_pkg::BOOT_SET:
      begin
        pc_mux_o = ctrl_pkg::PC_BOOT;
        pc_set_o = 1'b1;
        state_ns = ctrl_pkg::FIRST_FETCH;
      end

      // pipeline empty, wake on enable or pending exception
      ctrl_pkg::SLEEP:
      begin
        core_busy_o = 1'b0;
        instr_req_o = 1'b0;
        if (fetch_enable_i || exc_req_i)
          state_ns = ctrl_pkg::FIRST_FETCH;
      end

      // wait for the first instruction to reach ID
      ctrl_pkg::FIRST_FETCH:
      begin
        if (id_valid_i)
          state_ns = ctrl_pkg::DECODE;

        // an exception that woke the core is taken right away
        if (exc_req_i)
        begin
          pc_mux_o      = ctrl_pkg::PC_EXCEPTION;
          pc_set_o      = 1'b1;
          exc_ack_o     = 1'b1;
          exc_save_id_o = 1'b1;
        end
      end

      ctrl_pkg::DECODE:
      begin
        // the ID instruction is dead when EX takes a branch
        if (instr_valid_i && !branch_taken_ex_i)
        begin
          is_decoding_o = 1'b1;

          if ((jump_in_dec_i == ctrl_pkg::BRANCH_JAL) ||
              (jump_in_dec_i == ctrl_pkg::BRANCH_JALR))
          begin
            pc_mux_o = ctrl_pkg::PC_JUMP;
            // wait out a jr hazard, fire only once per instruction
            if (!jr_stall_i && !jump_done_q)
            begin
              pc_set_o  = 1'b1;
              jump_done = 1'b1;
            end
          end
          else if (exc_req_i)
          begin
            pc_mux_o      = ctrl_pkg::PC_EXCEPTION;
            pc_set_o      = 1'b1;
            exc_ack_o     = 1'b1;
            // keep the faulting instruction out of EX
            halt_id_o     = 1'b1;
            exc_save_id_o = 1'b1;
          end

          if (eret_insn_i)
          begin
            pc_mux_o         = ctrl_pkg::PC_ERET;
            exc_restore_id_o = 1'b1;
            if (!jump_done_q)
            begin
              pc_set_o  = 1'b1;
              jump_done = 1'b1;
            end
          end

          // wfi, or eret back into sleep
          if (pipe_flush_i || (eret_insn_i && !fetch_enable_i))
          begin
            halt_if_o = 1'b1;
            halt_id_o = 1'b1;
            state_ns  = ctrl_pkg::FLUSH_EX;
          end
        end

        // taken branch in EX wins over anything decoded in ID
        if (branch_taken_ex_i)
        begin
          pc_mux_o = ctrl_pkg::PC_BRANCH;
          pc_set_o = 1'b1;
        end
      end

      // let EX drain
      ctrl_pkg::FLUSH_EX:
      begin
        halt_if_o = 1'b1;
        if (ex_valid_i)
          state_ns = ctrl_pkg::FLUSH_WB;
      end

      // let WB drain, then sleep or resume
      ctrl_pkg::FLUSH_WB:
      begin
        halt_if_o = 1'b1;
        if (!fetch_enable_i)
        begin
          if (wb_valid_i)
            state_ns = ctrl_pkg::SLEEP;
        end
        else
        begin
          halt_if_o = 1'b0;
          if (id_valid_i)
            state_ns = ctrl_pkg::DECODE;
        end
      end

      default:
      begin
        instr_req_o = 1'b0;
        state_ns    = ctrl_pkg::RESET;
      end
    endcase
  end

  ////////////////////////////////////////
  // state registers
  ////////////////////////////////////////
  always_ff @(posedge clk or negedge rst_n)
  begin
    if (!rst_n)
    begin
      state_q     <= ctrl_pkg::RESET;
      jump_done_q <= 1'b0;
    end
    else
    begin
      state_q     <= state_ns;
      // cleared once ID hands the instruction on
      jump_done_q <= jump_done & ~id_valid_i;
    end
  end

  // no branch prediction, so EX cannot take branches back to back
  assert property (@(posedge clk) disable iff (!rst_n)
    branch_taken_ex_i |=> !branch_taken_ex_i)
    else $error("taken branches back to back");

endmodule

`default_nettype wire

// ==== controller/hazard_unit.sv ====
////////////////////////////////////////
// stall detection
////////////////////////////////////////

`timescale 1ns/1ps
`default_nettype none

module hazard_unit
(
  input  wire logic                         data_req_ex_i,
  input  wire ctrl_pkg::jump_kind_t         jump_in_dec_i,
  input  wire logic                         illegal_insn_i,
  input  wire logic                         is_decoding_i,
  input  wire logic [fwd_pkg::NUM_OPS-1:0]  ex_hit_i,
  input  wire logic                         wb_hit_a_i,
  input  wire logic                         alu_hit_a_i,

  output logic                              load_stall_o,
  output logic                              jr_stall_o,
  output logic                              deassert_we_o
);

  logic jalr_in_dec;

  assign jalr_in_dec = (jump_in_dec_i == ctrl_pkg::BRANCH_JALR);

  always_comb
  begin
    // load in EX targets one of our sources, result not ready yet
    load_stall_o = data_req_ex_i && (|ex_hit_i);

    // jalr target reg still in flight anywhere in the pipe
    // ex_hit_i[0] is operand a
    jr_stall_o = jalr_in_dec && (wb_hit_a_i || ex_hit_i[0] || alu_hit_a_i);

    // kill register writes of the ID instruction
    deassert_we_o = load_stall_o || jr_stall_o || illegal_insn_i || !is_decoding_i;
  end

endmodule

`default_nettype wire

// ==== riscv_ctrl_top.f ====
+incdir+test
common/ctrl_pkg.sv
common/fwd_pkg.sv
controller/ctrl_fsm.sv
controller/hazard_unit.sv
source/fwd_unit.sv
source/riscv_ctrl_top.sv
test/tb_riscv_ctrl.sv

// ==== run_sim.sh ====
#!/usr/bin/env bash
# build and run the controller testbench with verilator
set -e
set -o pipefail

cd "$(dirname "$0")"
rm -rf obj_dir sim.log

verilator --binary --timing --assert \
  -f riscv_ctrl_top.f \
  --top-module tb_riscv_ctrl \
  -o sim_tb

./obj_dir/sim_tb | tee sim.log

if grep -q "Test failed" sim.log; then
  echo "simulation reported a failure"
  exit 1
fi
echo "simulation clean"

// ==== source/fwd_unit.sv ====
////////////////////////////////////////
// operand forwarding
////////////////////////////////////////

`timescale 1ns/1ps
`default_nettype none

module fwd_unit
(
  input  wire fwd_pkg::reg_addr_t          raddr_a_i,
  input  wire fwd_pkg::reg_addr_t          raddr_b_i,
  input  wire fwd_pkg::reg_addr_t          raddr_c_i,
  input  wire fwd_pkg::reg_addr_t          waddr_ex_i,
  input  wire fwd_pkg::reg_addr_t          waddr_wb_i,
  input  wire fwd_pkg::reg_addr_t          alu_waddr_i,
  input  wire logic                        we_ex_i,
  input  wire logic                        we_wb_i,
  input  wire logic                        alu_we_i,

  output fwd_pkg::fwd_sel_t                operand_a_sel_o,
  output fwd_pkg::fwd_sel_t                operand_b_sel_o,
  output fwd_pkg::fwd_sel_t                operand_c_sel_o,
  output logic [fwd_pkg::NUM_OPS-1:0]      ex_hit_o,
  output logic                             wb_hit_a_o,
  output logic                             alu_hit_a_o
);

  // index 0 is a, 1 is b, 2 is c
  fwd_pkg::reg_addr_t                raddr [fwd_pkg::NUM_OPS];
  logic [fwd_pkg::NUM_OPS-1:0]       wb_hit;
  logic [fwd_pkg::NUM_OPS-1:0]       alu_hit;
  fwd_pkg::fwd_sel_t                 sel [fwd_pkg::NUM_OPS];

  assign raddr[0] = raddr_a_i;
  assign raddr[1] = raddr_b_i;
  assign raddr[2] = raddr_c_i;

  always_comb
  begin
    for (int i = 0; i < fwd_pkg::NUM_OPS; i++)
    begin
      // hits only count with their write enable, x0 included
      ex_hit_o[i] = we_ex_i && (raddr[i] == waddr_ex_i);
      wb_hit[i]   = we_wb_i && (raddr[i] == waddr_wb_i);
      alu_hit[i]  = alu_we_i && (raddr[i] == alu_waddr_i);

      // youngest result first
      if (alu_hit[i])
        sel[i] = fwd_pkg::SEL_FW_EX;
      else if (wb_hit[i])
        sel[i] = fwd_pkg::SEL_FW_WB;
      else
        sel[i] = fwd_pkg::SEL_REGFILE;
    end
  end

  assign operand_a_sel_o = sel[0];
  assign operand_b_sel_o = sel[1];
  assign operand_c_sel_o = sel[2];

  // operand a hits feed the jr stall check
  assign wb_hit_a_o  = wb_hit[0];
  assign alu_hit_a_o = alu_hit[0];

endmodule

`default_nettype wire

// ==== source/riscv_ctrl_top.sv ====
////////////////////////////////////////
// core controller top
////////////////////////////////////////

`timescale 1ns/1ps
`default_nettype none

module riscv_ctrl_top
(
  input  wire logic                 clk,
  input  wire logic                 rst_n,

  // decoder
  input  wire logic                 illegal_insn_i,
  input  wire logic                 eret_insn_i,
  input  wire logic                 pipe_flush_i,
  input  wire ctrl_pkg::jump_kind_t jump_in_dec_i,

  // pipeline status
  input  wire logic                 instr_valid_i,
  input  wire logic                 id_valid_i,
  input  wire logic                 ex_valid_i,
  input  wire logic                 wb_valid_i,
  input  wire logic                 branch_taken_ex_i,
  input  wire logic                 data_req_ex_i,

  input  wire logic                 exc_req_i,
  input  wire logic                 fetch_enable_i,

  // source and pending destination registers
  input  wire fwd_pkg::reg_addr_t   raddr_a_i,
  input  wire fwd_pkg::reg_addr_t   raddr_b_i,
  input  wire fwd_pkg::reg_addr_t   raddr_c_i,
  input  wire fwd_pkg::reg_addr_t   waddr_ex_i,
  input  wire logic                 we_ex_i,
  input  wire fwd_pkg::reg_addr_t   waddr_wb_i,
  input  wire logic                 we_wb_i,
  input  wire fwd_pkg::reg_addr_t   alu_waddr_i,
  input  wire logic                 alu_we_i,

  output logic                      core_busy_o,
  output logic                      is_decoding_o,
  output logic                      instr_req_o,
  output logic                      pc_set_o,
  output ctrl_pkg::pc_sel_t         pc_mux_o,
  output logic                      exc_ack_o,
  output logic                      exc_save_id_o,
  output logic                      exc_restore_id_o,
  output logic                      halt_if_o,
  output logic                      halt_id_o,
  output logic                      load_stall_o,
  output logic                      jr_stall_o,
  output logic                      deassert_we_o,
  output fwd_pkg::fwd_sel_t         operand_a_sel_o,
  output fwd_pkg::fwd_sel_t         operand_b_sel_o,
  output fwd_pkg::fwd_sel_t         operand_c_sel_o
);

  // address match results, forwarding to stall logic
  logic [fwd_pkg::NUM_OPS-1:0] ex_hit;
  logic                        wb_hit_a;
  logic                        alu_hit_a;

  ctrl_fsm u_ctrl_fsm (
    .clk               (clk),
    .rst_n             (rst_n),
    .fetch_enable_i    (fetch_enable_i),
    .instr_valid_i     (instr_valid_i),
    .eret_insn_i       (eret_insn_i),
    .pipe_flush_i      (pipe_flush_i),
    .jump_in_dec_i     (jump_in_dec_i),
    .branch_taken_ex_i (branch_taken_ex_i),
    .exc_req_i         (exc_req_i),
    .jr_stall_i        (jr_stall_o),
    .id_valid_i        (id_valid_i),
    .ex_valid_i        (ex_valid_i),
    .wb_valid_i        (wb_valid_i),
    .core_busy_o       (core_busy_o),
    .is_decoding_o     (is_decoding_o),
    .instr_req_o       (instr_req_o),
    .pc_set_o          (pc_set_o),
    .pc_mux_o          (pc_mux_o),
    .exc_ack_o         (exc_ack_o),
    .exc_save_id_o     (exc_save_id_o),
    .exc_restore_id_o  (exc_restore_id_o),
    .halt_if_o         (halt_if_o),
    .halt_id_o         (halt_id_o)
  );

  // stalls also gate the fsm jump redirect
  hazard_unit u_hazard_unit (
    .data_req_ex_i  (data_req_ex_i),
    .jump_in_dec_i  (jump_in_dec_i),
    .illegal_insn_i (illegal_insn_i),
    .is_decoding_i  (is_decoding_o),
    .ex_hit_i       (ex_hit),
    .wb_hit_a_i     (wb_hit_a),
    .alu_hit_a_i    (alu_hit_a),
    .load_stall_o   (load_stall_o),
    .jr_stall_o     (jr_stall_o),
    .deassert_we_o  (deassert_we_o)
  );

  fwd_unit u_fwd_unit (
    .raddr_a_i       (raddr_a_i),
    .raddr_b_i       (raddr_b_i),
    .raddr_c_i       (raddr_c_i),
    .waddr_ex_i      (waddr_ex_i),
    .waddr_wb_i      (waddr_wb_i),
    .alu_waddr_i     (alu_waddr_i),
    .we_ex_i         (we_ex_i),
    .we_wb_i         (we_wb_i),
    .alu_we_i        (alu_we_i),
    .operand_a_sel_o (operand_a_sel_o),
    .operand_b_sel_o (operand_b_sel_o),
    .operand_c_sel_o (operand_c_sel_o),
    .ex_hit_o        (ex_hit),
    .wb_hit_a_o      (wb_hit_a),
    .alu_hit_a_o     (alu_hit_a)
  );

endmodule

`default_nettype wire

// ==== test/tb_vectors.svh ====
////////////////////////////////////////
// hazard and forwarding vectors
////////////////////////////////////////

`ifndef TB_VECTORS_SVH
`define TB_VECTORS_SVH

// one row per cycle, applied with the controller sitting in DECODE
// columns
//   ra rb rc | wex eex | wwb ewb | walu ealu | load jump illegal valid
//   | sel_a sel_b sel_c | load_stall jr_stall deassert_we
// jump 0 none, 1 jal, 2 jalr, 3 cond
// sel 0 register file, 1 forward from EX, 2 forward from WB
typedef struct packed {
  fwd_pkg::reg_addr_t ra;
  fwd_pkg::reg_addr_t rb;
  fwd_pkg::reg_addr_t rc;
  fwd_pkg::reg_addr_t wex;
  logic               eex;
  fwd_pkg::reg_addr_t wwb;
  logic               ewb;
  fwd_pkg::reg_addr_t walu;
  logic               ealu;
  logic               load;
  logic [1:0]         jump;
  logic               illegal;
  logic               valid;
  logic [1:0]         sel_a;
  logic [1:0]         sel_b;
  logic [1:0]         sel_c;
  logic               lstall;
  logic               jstall;
  logic               dwe;
} vec_t;

localparam int N_VEC = 20;

vec_t vecs [N_VEC];

task automatic load_vectors();
  // no pending writes, then single alu and wb matches
  vecs[0]  = '{1, 2, 3, 0, 0, 0, 0, 0, 0, 0, 0, 0, 1, 0, 0, 0, 0, 0, 0};
  vecs[1]  = '{1, 2, 3, 0, 0, 0, 0, 1, 1, 0, 0, 0, 1, 1, 0, 0, 0, 0, 0};
  vecs[2]  = '{1, 2, 3, 0, 0, 2, 1, 0, 0, 0, 0, 0, 1, 0, 2, 0, 0, 0, 0};
  // alu beats wb on the same operand
  vecs[3]  = '{1, 2, 3, 0, 0, 3, 1, 3, 1, 0, 0, 0, 1, 0, 0, 1, 0, 0, 0};
  vecs[4]  = '{1, 2, 3, 0, 0, 1, 1, 2, 1, 0, 0, 0, 1, 2, 1, 0, 0, 0, 0};
  // matches with write enable low count for nothing
  vecs[5]  = '{1, 2, 3, 0, 0, 1, 0, 1, 0, 0, 0, 0, 1, 0, 0, 0, 0, 0, 0};
  vecs[6]  = '{7, 7, 7, 0, 0, 7, 1, 0, 0, 0, 0, 0, 1, 2, 2, 2, 0, 0, 0};
  // load in EX against b, then no load, then no EX write
  vecs[7]  = '{1, 2, 3, 2, 1, 0, 0, 0, 0, 1, 0, 0, 1, 0, 0, 0, 1, 0, 1};
  vecs[8]  = '{1, 2, 3, 3, 1, 0, 0, 0, 0, 0, 0, 0, 1, 0, 0, 0, 0, 0, 0};
  vecs[9]  = '{1, 2, 3, 1, 0, 0, 0, 0, 0, 1, 0, 0, 1, 0, 0, 0, 0, 0, 0};
  // jalr with operand a pending in EX, WB and ALU
  vecs[10] = '{1, 2, 3, 1, 1, 0, 0, 0, 0, 0, 2, 0, 1, 0, 0, 0, 0, 1, 1};
  vecs[11] = '{1, 2, 3, 0, 0, 1, 1, 0, 0, 0, 2, 0, 1, 2, 0, 0, 0, 1, 1};
  vecs[12] = '{1, 2, 3, 0, 0, 0, 0, 1, 1, 0, 2, 0, 1, 1, 0, 0, 0, 1, 1};
  // jalr hit on b only, jal and cond never jr stall
  vecs[13] = '{1, 2, 3, 0, 0, 0, 0, 2, 1, 0, 2, 0, 1, 0, 1, 0, 0, 0, 0};
  vecs[14] = '{1, 2, 3, 0, 0, 0, 0, 1, 1, 0, 1, 0, 1, 1, 0, 0, 0, 0, 0};
  vecs[15] = '{1, 2, 3, 1, 1, 0, 0, 0, 0, 0, 3, 0, 1, 0, 0, 0, 0, 0, 0};
  // illegal while decoding, then not decoding at all
  vecs[16] = '{1, 2, 3, 0, 0, 0, 0, 0, 0, 0, 0, 1, 1, 0, 0, 0, 0, 0, 1};
  vecs[17] = '{1, 2, 3, 0, 0, 0, 0, 0, 0, 0, 0, 0, 0, 0, 0, 0, 0, 0, 1};
  // load and jr stall together, x0 forwards like any register
  vecs[18] = '{4, 5, 6, 4, 1, 0, 0, 0, 0, 1, 2, 0, 1, 0, 0, 0, 1, 1, 1};
  vecs[19] = '{0, 0, 0, 0, 0, 0, 0, 0, 1, 0, 0, 0, 1, 1, 1, 1, 0, 0, 0};
endtask

`endif

// ==== test/tb_riscv_ctrl.sv ====
////////////////////////////////////////
// controller testbench
////////////////////////////////////////

`timescale 1ns/1ps
`default_nettype none

module tb_riscv_ctrl;

  logic                 clk;
  logic                 rst_n;

  logic                 illegal_insn_i;
  logic                 eret_insn_i;
  logic                 pipe_flush_i;
  ctrl_pkg::jump_kind_t jump_in_dec_i;
  logic                 instr_valid_i;
  logic                 id_valid_i;
  logic                 ex_valid_i;
  logic                 wb_valid_i;
  logic                 branch_taken_ex_i;
  logic                 data_req_ex_i;
  logic                 exc_req_i;
  logic                 fetch_enable_i;
  fwd_pkg::reg_addr_t   raddr_a_i;
  fwd_pkg::reg_addr_t   raddr_b_i;
  fwd_pkg::reg_addr_t   raddr_c_i;
  fwd_pkg::reg_addr_t   waddr_ex_i;
  logic                 we_ex_i;
  fwd_pkg::reg_addr_t   waddr_wb_i;
  logic                 we_wb_i;
  fwd_pkg::reg_addr_t   alu_waddr_i;
  logic                 alu_we_i;

  logic                 core_busy_o;
  logic                 is_decoding_o;
  logic                 instr_req_o;
  logic                 pc_set_o;
  ctrl_pkg::pc_sel_t    pc_mux_o;
  logic                 exc_ack_o;
  logic                 exc_save_id_o;
  logic                 exc_restore_id_o;
  logic                 halt_if_o;
  logic                 halt_id_o;
  logic                 load_stall_o;
  logic                 jr_stall_o;
  logic                 deassert_we_o;
  fwd_pkg::fwd_sel_t    operand_a_sel_o;
  fwd_pkg::fwd_sel_t    operand_b_sel_o;
  fwd_pkg::fwd_sel_t    operand_c_sel_o;

  `include "tb_vectors.svh"

  localparam int N_RAND      = 40;
  // every row is one cycle, the directed tests need far less than 200
  localparam int CYCLE_LIMIT = 2 * (N_VEC + N_RAND) + 200;

  int    errors          = 0;
  int    checks          = 0;
  int    tests_run       = 0;
  int    errors_at_start = 0;
  int    cycles          = 0;
  int    seed            = 32'hab882287;
  string test_name;
  vec_t  quiet;

  riscv_ctrl_top DUT (.*);

  ////////////////////////////////////////
  // clock and cycle limit
  ////////////////////////////////////////
  initial clk = 1'b0;

  always #5 clk = ~clk;

  always @(posedge clk)
  begin
    cycles++;
    if (cycles >= CYCLE_LIMIT)
    begin
      $display("timeout: run still going after %0d cycles", cycles);
      $display("Test failed");
      $finish;
    end
  end

  ////////////////////////////////////////
  // helpers
  ////////////////////////////////////////

  // inputs change 1 ns after the edge
  task automatic next_cycle();
    @(posedge clk);
    #1;
  endtask

  // mid cycle, combinational outputs have settled
  task automatic settle();
    #5;
  endtask

  task automatic check_value(input string what, input logic [31:0] got,
                             input logic [31:0] exp);
    checks++;
    if (got !== exp)
    begin
      errors++;
      $display("ERROR at %0t: %s is %0h, expected %0h", $time, what, got, exp);
    end
  endtask

  task automatic start_test(input string name);
    test_name       = name;
    errors_at_start = errors;
  endtask

  task automatic end_test();
    tests_run++;
    $display("test %s done with %0d errors", test_name, errors - errors_at_start);
  endtask

  task automatic drive_row(input vec_t v);
    raddr_a_i      = v.ra;
    raddr_b_i      = v.rb;
    raddr_c_i      = v.rc;
    waddr_ex_i     = v.wex;
    we_ex_i        = v.eex;
    waddr_wb_i     = v.wwb;
    we_wb_i        = v.ewb;
    alu_waddr_i    = v.walu;
    alu_we_i       = v.ealu;
    data_req_ex_i  = v.load;
    jump_in_dec_i  = ctrl_pkg::jump_kind_t'(v.jump);
    illegal_insn_i = v.illegal;
    instr_valid_i  = v.valid;
  endtask

  task automatic apply_row(input vec_t v, input int idx);
    next_cycle();
    drive_row(v);
    settle();
    check_value($sformatf("row %0d operand_a_sel_o", idx), 32'(operand_a_sel_o), 32'(v.sel_a));
    check_value($sformatf("row %0d operand_b_sel_o", idx), 32'(operand_b_sel_o), 32'(v.sel_b));
    check_value($sformatf("row %0d operand_c_sel_o", idx), 32'(operand_c_sel_o), 32'(v.sel_c));
    check_value($sformatf("row %0d load_stall_o", idx), 32'(load_stall_o), 32'(v.lstall));
    check_value($sformatf("row %0d jr_stall_o", idx), 32'(jr_stall_o), 32'(v.jstall));
    check_value($sformatf("row %0d deassert_we_o", idx), 32'(deassert_we_o), 32'(v.dwe));
  endtask

  // alu result is youngest, then wb, else the register file
  function automatic logic [1:0] select_for(input fwd_pkg::reg_addr_t addr, input vec_t v);
    if (v.ealu && addr == v.walu)
      return fwd_pkg::SEL_FW_EX;
    else if (v.ewb && addr == v.wwb)
      return fwd_pkg::SEL_FW_WB;
    else
      return fwd_pkg::SEL_REGFILE;
  endfunction

  task automatic predict_row(inout vec_t v);
    logic ex_any;
    logic a_pending;
    ex_any    = v.eex && (v.ra == v.wex || v.rb == v.wex || v.rc == v.wex);
    a_pending = (v.eex && v.ra == v.wex) || (v.ewb && v.ra == v.wwb) ||
                (v.ealu && v.ra == v.walu);
    v.sel_a  = select_for(v.ra, v);
    v.sel_b  = select_for(v.rb, v);
    v.sel_c  = select_for(v.rc, v);
    v.lstall = v.load && ex_any;
    v.jstall = (v.jump == ctrl_pkg::BRANCH_JALR) && a_pending;
    v.dwe    = v.lstall || v.jstall || v.illegal || !v.valid;
  endtask

  // few addresses so matches happen often
  task automatic make_random_row(output vec_t v);
    v         = '0;
    v.ra      = 5'($random(seed) & 3);
    v.rb      = 5'($random(seed) & 3);
    v.rc      = 5'($random(seed) & 3);
    v.wex     = 5'($random(seed) & 3);
    v.eex     = 1'($random(seed));
    v.wwb     = 5'($random(seed) & 3);
    v.ewb     = 1'($random(seed));
    v.walu    = 5'($random(seed) & 3);
    v.ealu    = 1'($random(seed));
    v.load    = 1'($random(seed));
    v.jump    = 2'($random(seed));
    v.illegal = (($random(seed) & 7) == 0);
    v.valid   = (($random(seed) & 7) != 0);
    predict_row(v);
  endtask

  ////////////////////////////////////////
  // tests
  ////////////////////////////////////////

  task automatic boot_from_reset();
    start_test("reset_boot");
    settle();
    check_value("core_busy_o in reset", 32'(core_busy_o), 0);
    check_value("instr_req_o in reset", 32'(instr_req_o), 0);
    check_value("deassert_we_o in reset", 32'(deassert_we_o), 1);
    check_value("pc_set_o in reset", 32'(pc_set_o), 0);
    next_cycle();
    fetch_enable_i = 1'b1;
    // boot address goes out one cycle after the enable
    next_cycle();
    settle();
    check_value("boot pc_set_o", 32'(pc_set_o), 1);
    check_value("boot pc_mux_o", 32'(pc_mux_o), 32'(ctrl_pkg::PC_BOOT));
    next_cycle();
    instr_valid_i = 1'b1;
    id_valid_i    = 1'b1;
    settle();
    check_value("pc_set_o after boot", 32'(pc_set_o), 0);
    while (!is_decoding_o)
    begin
      next_cycle();
      settle();
    end
    check_value("core_busy_o decoding", 32'(core_busy_o), 1);
    check_value("instr_req_o decoding", 32'(instr_req_o), 1);
    check_value("deassert_we_o decoding", 32'(deassert_we_o), 0);
    end_test();
  endtask

  task automatic sweep_vector_table();
    start_test("vector_table");
    for (int i = 0; i < N_VEC; i++)
      apply_row(vecs[i], i);
    end_test();
  endtask

  task automatic sweep_random_rows();
    vec_t v;
    start_test("random_rows");
    for (int i = 0; i < N_RAND; i++)
    begin
      make_random_row(v);
      apply_row(v, N_VEC + i);
    end
    end_test();
  endtask

  task automatic exercise_redirects();
    int pulses;
    start_test("redirects");
    pulses = 0;
    // jal held in ID, one redirect only
    next_cycle();
    jump_in_dec_i = ctrl_pkg::BRANCH_JAL;
    id_valid_i    = 1'b0;
    for (int i = 0; i < 4; i++)
    begin
      settle();
      if (pc_set_o)
      begin
        pulses++;
        check_value("jal pc_mux_o", 32'(pc_mux_o), 32'(ctrl_pkg::PC_JUMP));
      end
      next_cycle();
    end
    id_valid_i = 1'b1;
    settle();
    check_value("jal pc_set_o on accept", 32'(pc_set_o), 0);
    check_value("jal pulse count", pulses, 1);

    // jalr waits while its base register is pending in EX
    next_cycle();
    jump_in_dec_i = ctrl_pkg::BRANCH_JALR;
    id_valid_i    = 1'b0;
    raddr_a_i     = 5'd9;
    waddr_ex_i    = 5'd9;
    we_ex_i       = 1'b1;
    settle();
    check_value("jalr jr_stall_o", 32'(jr_stall_o), 1);
    check_value("jalr pc_set_o held", 32'(pc_set_o), 0);
    next_cycle();
    settle();
    check_value("jalr pc_set_o still held", 32'(pc_set_o), 0);
    next_cycle();
    we_ex_i = 1'b0;
    settle();
    while (!pc_set_o)
    begin
      next_cycle();
      settle();
    end
    check_value("jalr jr_stall_o cleared", 32'(jr_stall_o), 0);
    check_value("jalr pc_mux_o", 32'(pc_mux_o), 32'(ctrl_pkg::PC_JUMP));
    next_cycle();
    jump_in_dec_i = ctrl_pkg::BRANCH_NONE;
    id_valid_i    = 1'b1;
    raddr_a_i     = 5'd0;
    waddr_ex_i    = 5'd0;

    // taken branch kills the ID instruction
    next_cycle();
    branch_taken_ex_i = 1'b1;
    settle();
    check_value("branch pc_set_o", 32'(pc_set_o), 1);
    check_value("branch pc_mux_o", 32'(pc_mux_o), 32'(ctrl_pkg::PC_BRANCH));
    check_value("branch is_decoding_o", 32'(is_decoding_o), 0);
    next_cycle();
    branch_taken_ex_i = 1'b0;
    settle();
    check_value("is_decoding_o after branch", 32'(is_decoding_o), 1);
    end_test();
  endtask

  task automatic take_exception_and_eret();
    start_test("exception_eret");
    next_cycle();
    exc_req_i = 1'b1;
    settle();
    check_value("exc_ack_o", 32'(exc_ack_o), 1);
    check_value("exc_save_id_o", 32'(exc_save_id_o), 1);
    check_value("exc halt_id_o", 32'(halt_id_o), 1);
    check_value("exc pc_set_o", 32'(pc_set_o), 1);
    check_value("exc pc_mux_o", 32'(pc_mux_o), 32'(ctrl_pkg::PC_EXCEPTION));
    next_cycle();
    exc_req_i = 1'b0;
    settle();
    check_value("exc_ack_o after request", 32'(exc_ack_o), 0);

    // eret with fetch enabled stays in decode
    next_cycle();
    eret_insn_i = 1'b1;
    id_valid_i  = 1'b0;
    settle();
    check_value("eret pc_set_o", 32'(pc_set_o), 1);
    check_value("eret pc_mux_o", 32'(pc_mux_o), 32'(ctrl_pkg::PC_ERET));
    check_value("eret exc_restore_id_o", 32'(exc_restore_id_o), 1);
    check_value("eret halt_if_o", 32'(halt_if_o), 0);
    next_cycle();
    id_valid_i = 1'b1;
    settle();
    check_value("eret pc_set_o once", 32'(pc_set_o), 0);
    next_cycle();
    eret_insn_i = 1'b0;
    settle();
    check_value("exc_restore_id_o after eret", 32'(exc_restore_id_o), 0);
    end_test();
  endtask

  task automatic flush_to_sleep_and_wake();
    start_test("flush_sleep");
    next_cycle();
    pipe_flush_i   = 1'b1;
    fetch_enable_i = 1'b0;
    settle();
    check_value("flush halt_if_o", 32'(halt_if_o), 1);
    check_value("flush halt_id_o", 32'(halt_id_o), 1);
    next_cycle();
    pipe_flush_i = 1'b0;
    id_valid_i   = 1'b0;
    ex_valid_i   = 1'b1;
    settle();
    check_value("flush_ex halt_if_o", 32'(halt_if_o), 1);
    next_cycle();
    ex_valid_i = 1'b0;
    wb_valid_i = 1'b1;
    settle();
    while (core_busy_o)
    begin
      next_cycle();
      settle();
    end
    check_value("sleep instr_req_o", 32'(instr_req_o), 0);

    // pending exception wakes the core
    next_cycle();
    wb_valid_i = 1'b0;
    exc_req_i  = 1'b1;
    settle();
    while (!instr_req_o)
    begin
      next_cycle();
      settle();
    end
    check_value("wake core_busy_o", 32'(core_busy_o), 1);
    check_value("wake exc_ack_o", 32'(exc_ack_o), 1);
    next_cycle();
    exc_req_i = 1'b0;
    end_test();
  endtask

  ////////////////////////////////////////
  // main sequence
  ////////////////////////////////////////
  initial
  begin
    quiet             = '0;
    rst_n             = 1'b0;
    fetch_enable_i    = 1'b0;
    id_valid_i        = 1'b0;
    ex_valid_i        = 1'b0;
    wb_valid_i        = 1'b0;
    branch_taken_ex_i = 1'b0;
    exc_req_i         = 1'b0;
    eret_insn_i       = 1'b0;
    pipe_flush_i      = 1'b0;
    drive_row(quiet);
    load_vectors();

    repeat (10) @(posedge clk);
    #1;
    rst_n = 1'b1;

    boot_from_reset();
    sweep_vector_table();
    sweep_random_rows();

    // back to a plain decoding instruction, nothing pending
    quiet.valid = 1'b1;
    next_cycle();
    drive_row(quiet);

    exercise_redirects();
    take_exception_and_eret();
    flush_to_sleep_and_wake();

    $display("summary: %0d tests, %0d checks, %0d errors", tests_run, checks, errors);
    if (errors == 0)
      $display("Test completed successfully");
    else
      $display("Test failed");
    $finish;
  end

endmodule

`default_nettype wire
